// ==== id_bridge_top.f ====
+incdir+design
design/bridge_pkg.sv
design/cam_ports_if.sv
design/bridge_cam.sv
design/req_arbiter.sv
design/resp_router.sv
design/id_bridge_top.sv
tests/tb_clock.sv
tests/tb_id_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ID bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f id_bridge_top.f --top-module tb_id_bridge \
    --Mdir obj_dir -o tb_id_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_id_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== tests/tb_id_bridge.sv ====
`include "bridge_defines.svh"

module tb_id_bridge import bridge_pkg::*; ();

    localparam int NM            = `BRIDGE_NUM_MASTERS;
    localparam int DEPTH         = `BRIDGE_CAM_DEPTH;
    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_CYCLES = 200;
    // Directed sections need well under 200 cycles
    localparam int TEST_CYCLES   = RANDOM_CYCLES + 200;
    localparam int MARGIN_CYCLES = 200;

    logic clk;
    logic reset;
    logic [NM-1:0] req_valid;
    tag_t          req_tag [NM];
    logic [NM-1:0] req_accept;
    logic          out_valid;
    tag_t          out_tag;
    master_idx_t   out_master;
    logic          resp_valid;
    tag_t          resp_tag;
    resp_data_t    resp_data;
    logic [NM-1:0] master_resp_valid;
    resp_data_t    master_resp_data;
    logic          orphan_error;
    cam_count_t    tracker_count;
    logic          tracker_empty;
    integer        seed;

    // ==============================
    // Reference model state
    // ==============================

    // Outstanding transactions in acceptance order
    // The first entry with a given ID heads that ID's queue
    tag_t          model_tag [$];
    master_idx_t   model_master [$];
    int            model_ptr = 0;
    int            model_occ = 0;
    // Registered outputs expected in the current cycle
    logic          exp_out_valid = 1'b0;
    tag_t          exp_out_tag = '0;
    master_idx_t   exp_out_master = '0;
    logic [NM-1:0] exp_resp_valid = '0;
    resp_data_t    exp_resp_data = '0;
    logic          exp_orphan = 1'b0;
    logic [NM-1:0] accepted_now = '0;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    id_bridge_top dut (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_tag(req_tag), .req_accept(req_accept),
        .out_valid(out_valid), .out_tag(out_tag), .out_master(out_master),
        .resp_valid(resp_valid), .resp_tag(resp_tag), .resp_data(resp_data),
        .master_resp_valid(master_resp_valid), .master_resp_data(master_resp_data),
        .orphan_error(orphan_error), .tracker_count(tracker_count),
        .tracker_empty(tracker_empty)
    );

    // One model step per cycle, returns the expected accept vector
    function automatic logic [NM-1:0] reference_cycle();
        logic [NM-1:0] grant;
        logic          full;
        int            hit_pos;
        int            winner;
        int            cand;
        grant          = '0;
        full           = (model_occ == DEPTH);
        hit_pos        = -1;
        winner         = -1;
        exp_out_valid  = 1'b0;
        exp_resp_valid = '0;
        exp_orphan     = 1'b0;
        // Response sees only entries allocated before this cycle
        if (resp_valid) begin
            for (int i = 0; i < model_tag.size(); i++) begin
                if (hit_pos < 0 && model_tag[i] == resp_tag) begin
                    hit_pos = i;
                end
            end
            if (hit_pos < 0) begin
                exp_orphan = 1'b1;
            end else begin
                exp_resp_valid[model_master[hit_pos]] = 1'b1;
                exp_resp_data = resp_data;
                model_tag.delete(hit_pos);
                model_master.delete(hit_pos);
                model_occ--;
            end
        end
        // First requester at or after the pointer, nobody while full
        if (!full) begin
            for (int k = 0; k < NM; k++) begin
                cand = (model_ptr + k) % NM;
                if (winner < 0 && req_valid[cand]) begin
                    winner = cand;
                end
            end
        end
        if (winner >= 0) begin
            grant[winner]  = 1'b1;
            exp_out_valid  = 1'b1;
            exp_out_tag    = req_tag[winner];
            exp_out_master = master_idx_t'(winner);
            model_tag.push_back(req_tag[winner]);
            model_master.push_back(master_idx_t'(winner));
            model_ptr = (winner + 1) % NM;
            model_occ++;
        end
        return grant;
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_tag(input string name, input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            $display("FAILED time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_master(input string name, input master_idx_t expected,
                                  input master_idx_t actual);
        if (actual !== expected) begin
            $display("FAILED time %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_data(input string name, input resp_data_t expected,
                                input resp_data_t actual);
        if (actual !== expected) begin
            $display("FAILED time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_count(input string name, input cam_count_t expected,
                                 input cam_count_t actual);
        if (actual !== expected) begin
            $display("FAILED time %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Registered outputs against what the model predicted one cycle earlier
    task automatic check_registered();
        if (out_valid !== exp_out_valid) begin
            report_failure("downstream issue pulse missing or unexpected");
        end
        if (exp_out_valid) begin
            compare_tag("out_tag", exp_out_tag, out_tag);
            compare_master("out_master", exp_out_master, out_master);
        end
        if (master_resp_valid !== exp_resp_valid) begin
            report_failure("master response pulse missing, extra or on the wrong master");
        end
        if (exp_resp_valid != '0) begin
            compare_data("master_resp_data", exp_resp_data, master_resp_data);
        end
        if (orphan_error !== exp_orphan) begin
            report_failure("orphan_error pulse missing or unexpected");
        end
        compare_count("tracker_count", cam_count_t'(model_occ), tracker_count);
        if (tracker_empty !== (model_occ == 0)) begin
            report_failure("tracker_empty does not follow the occupancy");
        end
    endtask

    // Mid-cycle sampling, well away from the edge and the input update
    always @(negedge clk) begin
        if (!reset) begin
            check_registered();
            accepted_now = reference_cycle();
            if (req_accept !== accepted_now) begin
                report_failure("accept pulse missing, extra or on the wrong master");
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Accepted masters drop their request, responses last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #2;
        req_valid  = req_valid & ~accepted_now;
        resp_valid = 1'b0;
    endtask

    task automatic issue_request(input int m, input tag_t t);
        req_valid[m] = 1'b1;
        req_tag[m]   = t;
    endtask

    task automatic send_response(input tag_t t);
        resp_valid = 1'b1;
        resp_tag   = t;
        resp_data  = resp_data_t'($random(seed));
    endtask

    task automatic wait_requests_done();
        while (req_valid != '0) begin
            next_cycle();
        end
    endtask

    // Answer the oldest outstanding entry every cycle until all is quiet
    task automatic drain();
        while ((req_valid != '0) || (model_tag.size() > 0)) begin
            if (model_tag.size() > 0) begin
                send_response(model_tag[0]);
            end
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    initial begin
        seed       = 32'h44fae4a3;
        req_valid  = '0;
        resp_valid = 1'b0;
        resp_tag   = '0;
        resp_data  = '0;
        for (int m = 0; m < NM; m++) begin
            req_tag[m] = '0;
        end
        wait (!reset);
        // Idle after reset
        repeat (5) next_cycle();
        // One request per master, then its response
        for (int m = 0; m < NM; m++) begin
            issue_request(m, tag_t'(m + 3));
            wait_requests_done();
            drain();
        end
        // All masters at once, rotation from master 0
        for (int m = 0; m < NM; m++) begin
            issue_request(m, tag_t'(m + 8));
        end
        wait_requests_done();
        drain();
        // Shared ID answered in acceptance order
        for (int m = 0; m < NM; m++) begin
            issue_request(m, 4'h5);
        end
        wait_requests_done();
        drain();
        // Fill the tracker, then hold one more request
        for (int r = 0; r < 2; r++) begin
            for (int m = 0; m < NM; m++) begin
                issue_request(m, tag_t'(rand_below(16)));
            end
            wait_requests_done();
        end
        issue_request(0, 4'hc);
        // Nothing reaches downstream while all eight entries are held
        for (int c = 0; c < 4; c++) begin
            next_cycle();
            compare_count("tracker_count", cam_count_t'(DEPTH), tracker_count);
            if (out_valid !== 1'b0) begin
                report_failure("request issued while the tracker was full");
            end
        end
        send_response(model_tag[0]);
        repeat (2) next_cycle();
        // Slot freed by the response lets the held request issue
        if (out_valid !== 1'b1) begin
            report_failure("request still waiting after a tracker slot was freed");
        end
        compare_tag("out_tag", 4'hc, out_tag);
        compare_master("out_master", master_idx_t'(0), out_master);
        drain();
        // Orphans with and without outstanding entries
        send_response(4'h7);
        repeat (2) next_cycle();
        issue_request(1, 4'h2);
        wait_requests_done();
        send_response(4'h9);
        repeat (2) next_cycle();
        drain();
        // Random mix, mostly tracked IDs in the responses
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int m = 0; m < NM; m++) begin
                if (!req_valid[m] && rand_below(2) == 1) begin
                    issue_request(m, tag_t'(rand_below(16)));
                end
            end
            if (rand_below(2) == 1) begin
                if (model_tag.size() > 0 && rand_below(4) != 0) begin
                    send_response(model_tag[rand_below(model_tag.size())]);
                end else begin
                    send_response(tag_t'(rand_below(16)));
                end
            end
            next_cycle();
        end
        drain();
        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout after %0d cycles, tests did not finish", TEST_CYCLES + MARGIN_CYCLES);
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule : tb_id_bridge

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    // Free-running clock, period 20
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released just after a rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule : tb_clock

// ==== design/id_bridge_top.sv ====
`include "bridge_defines.svh"

module id_bridge_top import bridge_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,

    // Master requests
    input  logic [`BRIDGE_NUM_MASTERS-1:0] req_valid,
    input  tag_t                           req_tag [`BRIDGE_NUM_MASTERS],
    output logic [`BRIDGE_NUM_MASTERS-1:0] req_accept,

    // Downstream issue
    output logic                           out_valid,
    output tag_t                           out_tag,
    output master_idx_t                    out_master,

    // Downstream responses
    input  logic                           resp_valid,
    input  tag_t                           resp_tag,
    input  resp_data_t                     resp_data,

    // Responses back to the masters
    output logic [`BRIDGE_NUM_MASTERS-1:0] master_resp_valid,
    output resp_data_t                     master_resp_data,

    // Tracker status
    output logic                           orphan_error,
    output cam_count_t                     tracker_count,
    output logic                           tracker_empty
);

    // Internal CAM ports
    cam_alloc_if alloc_bus ();
    cam_evict_if evict_bus ();

    // ==============================
    // Request path
    // ==============================

    req_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_tag    (req_tag),
        .req_accept (req_accept),
        .alloc      (alloc_bus.requester),
        .out_valid  (out_valid),
        .out_tag    (out_tag),
        .out_master (out_master)
    );

    // ID tracker
    bridge_cam u_cam (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc_bus.cam),
        .evict      (evict_bus.cam),
        .tags_count (tracker_count),
        .tags_empty (tracker_empty)
    );

    // ==============================
    // Response path
    // ==============================

    resp_router u_router (
        .clk               (clk),
        .reset             (reset),
        .resp_valid        (resp_valid),
        .resp_tag          (resp_tag),
        .resp_data         (resp_data),
        .evict             (evict_bus.releaser),
        .master_resp_valid (master_resp_valid),
        .master_resp_data  (master_resp_data),
        .orphan_error      (orphan_error)
    );

endmodule : id_bridge_top

// ==== design/resp_router.sv ====
`include "bridge_defines.svh"

module resp_router import bridge_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           resp_valid,
    input  tag_t                           resp_tag,
    input  resp_data_t                     resp_data,
    cam_evict_if.releaser                  evict,
    output logic [`BRIDGE_NUM_MASTERS-1:0] master_resp_valid,
    output resp_data_t                     master_resp_data,
    output logic                           orphan_error
);

    // Lookup result decoded to a per-master strobe
    logic [`BRIDGE_NUM_MASTERS-1:0] target_onehot;
    logic                           hit;

    // ==============================
    // Lookup
    // ==============================

    // Every response frees its entry in the arrival cycle
    assign evict.deallocate     = resp_valid;
    assign evict.deallocate_tag = resp_tag;

    // Only the oldest entry of an ID may answer
    assign hit = evict.deallocate_valid && (evict.deallocate_count == '0);

    always_comb begin
        target_onehot = '0;
        target_onehot[evict.deallocate_data] = 1'b1;
    end

    // ==============================
    // Output stage
    // ==============================

    // Fixed one-cycle latency, never stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            master_resp_valid <= '0;
            orphan_error      <= 1'b0;
        end else begin
            master_resp_valid <= (resp_valid && hit) ? target_onehot : '0;
            // ID with nothing outstanding
            orphan_error      <= resp_valid && !hit;
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk) begin
        if (resp_valid) begin
            master_resp_data <= resp_data;
        end
    end

endmodule : resp_router

// ==== design/req_arbiter.sv ====
`include "bridge_defines.svh"

module req_arbiter import bridge_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`BRIDGE_NUM_MASTERS-1:0] req_valid,
    input  tag_t                           req_tag [`BRIDGE_NUM_MASTERS],
    output logic [`BRIDGE_NUM_MASTERS-1:0] req_accept,
    cam_alloc_if.requester                 alloc,
    output logic                           out_valid,
    output tag_t                           out_tag,
    output master_idx_t                    out_master
);

    localparam int NUM = `BRIDGE_NUM_MASTERS;

    // Master with the highest priority this cycle
    master_idx_t rr_ptr;

    master_idx_t grant_idx;
    logic        grant_found;
    logic        grant;

    // ==============================
    // Round-robin search
    // ==============================

    // First requester at or after the pointer
    // Walking the offsets downward leaves the nearest one in grant_idx
    always_comb begin
        master_idx_t cand;
        grant_idx   = '0;
        grant_found = 1'b0;
        for (int k = NUM - 1; k >= 0; k--) begin
            cand = master_idx_t'((int'(rr_ptr) + k) % NUM);
            if (req_valid[cand]) begin
                grant_idx   = cand;
                grant_found = 1'b1;
            end
        end
    end

    // No grant while the tracker is full
    assign grant = grant_found && !alloc.full;

    always_comb begin
        req_accept = '0;
        req_accept[grant_idx] = grant;
    end

    // Allocation happens in the accept cycle
    assign alloc.allocate      = grant;
    assign alloc.allocate_tag  = req_tag[grant_idx];
    assign alloc.allocate_data = grant_idx;

    // ==============================
    // Pointer and downstream issue
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant;
            if (grant) begin
                // One past the winner, wrapping at the last master
                rr_ptr <= (int'(grant_idx) == NUM - 1) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    // Issued request payload
    always_ff @(posedge clk) begin
        if (grant) begin
            out_tag    <= req_tag[grant_idx];
            out_master <= grant_idx;
        end
    end

endmodule : req_arbiter

// ==== design/bridge_cam.sv ====
`include "bridge_defines.svh"

module bridge_cam import bridge_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    cam_alloc_if.cam    alloc,
    cam_evict_if.cam    evict,
    output cam_count_t  tags_count,
    output logic        tags_empty
);

    localparam int DEPTH = `BRIDGE_CAM_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // ==============================
    // Entry storage
    // ==============================

    tag_t        tag_array   [DEPTH];
    master_idx_t data_array  [DEPTH];
    // Position of the entry among entries with the same ID, 0 is oldest
    cam_count_t  order_array [DEPTH];
    logic [DEPTH-1:0] valid;

    // Number of live entries
    cam_count_t occupancy;

    // Per-port match vectors
    logic [DEPTH-1:0] entry_matches;
    logic [DEPTH-1:0] evict_matches;

    logic [IDX_W-1:0] free_loc;
    logic             entry_hit;
    cam_count_t       max_order;
    cam_count_t       new_order;

    logic [IDX_W-1:0] evict_loc;
    logic             evict_found;

    logic alloc_fire;
    logic evict_fire;

    // ==============================
    // Lookup
    // ==============================

    // Both ports compare against every live entry
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entry_matches[i] = valid[i] && (tag_array[i] == alloc.allocate_tag);
            evict_matches[i] = valid[i] && (tag_array[i] == evict.deallocate_tag);
        end
    end

    assign entry_hit = |entry_matches;

    // Lowest free slot
    // Scanning downward lets the lowest index overwrite the rest
    always_comb begin
        free_loc = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_loc = IDX_W'(i);
            end
        end
    end

    // Youngest position already held by the allocating ID
    always_comb begin
        max_order = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entry_matches[i] && (order_array[i] > max_order)) begin
                max_order = order_array[i];
            end
        end
    end

    // Oldest entry of the evicting ID
    always_comb begin
        evict_loc   = '0;
        evict_found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (evict_matches[i] && (order_array[i] == '0)) begin
                evict_loc   = IDX_W'(i);
                evict_found = 1'b1;
            end
        end
    end

    assign alloc_fire = alloc.allocate && !alloc.full;
    assign evict_fire = evict.deallocate && evict_found;

    // Ordering position for the new entry
    always_comb begin
        if (!entry_hit) begin
            // First occurrence of this ID
            new_order = '0;
        end else if (evict_fire && (alloc.allocate_tag == evict.deallocate_tag)) begin
            // Same ID leaves this cycle so every older entry moves up by one
            new_order = max_order;
        end else begin
            new_order = max_order + 1'b1;
        end
    end

    // Eviction results, combinational
    assign evict.deallocate_valid = evict_found;
    assign evict.deallocate_data  = evict_found ? data_array[evict_loc] : '0;
    assign evict.deallocate_count = evict_found ? order_array[evict_loc] : '0;

    // ==============================
    // Update
    // ==============================

    // Valid bits and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            valid     <= '0;
            occupancy <= '0;
        end else begin
            if (alloc_fire) begin
                valid[free_loc] <= 1'b1;
            end
            // Freed slot is live, new slot is free, so they never collide
            if (evict_fire) begin
                valid[evict_loc] <= 1'b0;
            end
            case ({alloc_fire, evict_fire})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            tag_array[free_loc]   <= alloc.allocate_tag;
            data_array[free_loc]  <= alloc.allocate_data;
            order_array[free_loc] <= new_order;
        end
        // Younger entries of the evicted ID move one place forward
        if (evict_fire) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (evict_matches[j] && (IDX_W'(j) != evict_loc)) begin
                    order_array[j] <= order_array[j] - 1'b1;
                end
            end
        end
    end

    // ==============================
    // Status
    // ==============================

    assign alloc.full = (occupancy == cam_count_t'(DEPTH));
    assign tags_empty = (occupancy == '0);
    assign tags_count = occupancy;

endmodule : bridge_cam

// ==== design/cam_ports_if.sv ====
`include "bridge_defines.svh"

// Allocation port of the tracker CAM
interface cam_alloc_if import bridge_pkg::*; ();
    logic        allocate;
    tag_t        allocate_tag;
    master_idx_t allocate_data;
    logic        full;

    // Arbiter side
    modport requester (output allocate, output allocate_tag, output allocate_data,
                       input full);

    // Storage side
    modport cam (input allocate, input allocate_tag, input allocate_data,
                 output full);
endinterface : cam_alloc_if

// Eviction port of the tracker CAM
interface cam_evict_if import bridge_pkg::*; ();
    logic        deallocate;
    tag_t        deallocate_tag;
    logic        deallocate_valid;
    master_idx_t deallocate_data;
    cam_count_t  deallocate_count;

    // Response side
    modport releaser (output deallocate, output deallocate_tag,
                      input deallocate_valid, input deallocate_data, input deallocate_count);

    // Lookup results come back in the same cycle
    modport cam (input deallocate, input deallocate_tag,
                 output deallocate_valid, output deallocate_data, output deallocate_count);
endinterface : cam_evict_if

// ==== design/bridge_pkg.sv ====
`include "bridge_defines.svh"

package bridge_pkg;

    // ==============================
    // Shared bridge types
    // ==============================

    // Transaction ID as carried on requests and responses
    typedef logic [`BRIDGE_TAG_WIDTH-1:0] tag_t;

    // Index of an issuing master
    typedef logic [$clog2(`BRIDGE_NUM_MASTERS)-1:0] master_idx_t;

    // Response payload
    typedef logic [`BRIDGE_DATA_WIDTH-1:0] resp_data_t;

    // Occupancy or ordering count
    // One extra bit so a full tracker is representable
    typedef logic [$clog2(`BRIDGE_CAM_DEPTH):0] cam_count_t;

endpackage : bridge_pkg

// ==== design/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// ==============================
// Bridge sizing
// ==============================

// Transaction ID width in bits
`define BRIDGE_TAG_WIDTH 4

// Response payload width in bits
`define BRIDGE_DATA_WIDTH 16

// Number of requesting masters
`define BRIDGE_NUM_MASTERS 4

// Tracker capacity in outstanding transactions
`define BRIDGE_CAM_DEPTH 8

`endif
